// File: sim.f
+incdir+.
source/rtos_pkg.sv
source/rtos_bus_decode.sv
source/rtos_ready_queue.sv
source/rtos_cpu_ctl.sv
source/rtos_event_flag.sv
source/rtos_systim.sv
source/rtos_top.sv
verification/tb_clock_gen.sv
verification/rtos_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the rtos kernel testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module rtos_tb -o sim_rtos
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed"
    exit $status
fi

./obj_dir/sim_rtos
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

// File: verification/rtos_tb.sv
// rtos kernel testbench: bus stimulus, reference model and compare checks
`include "rtos_consts.svh"

module rtos_tb;
    import rtos_pkg::*;

    localparam int ACK_LIMIT   = 20;
    localparam int CYCLE_LIMIT = 20000;
    localparam int TSK_OPS     = 200;
    localparam int FLG_OPS     = 60;
    localparam int TIM_RUNS    = 5;

    logic                          clk;
    logic                          arst_n_i;
    logic [`RTOS_WB_ADR_WIDTH-1:0] wb_adr_i;
    wb_dat_t                       wb_dat_i;
    logic                          wb_we_i;
    logic [`RTOS_WB_SEL_WIDTH-1:0] wb_sel_i;
    logic                          wb_stb_i;
    flgptn_t                       extflg_i;
    wb_dat_t                       wb_dat_o;
    logic                          wb_ack_o;
    logic                          irq_o;
    tskid_t                        top_tskid_o;
    tskid_t                        run_tskid_o;

    // reference model state
    logic    ready_m [1:`RTOS_TMAX_TSKID];
    tskpri_t pri_m   [1:`RTOS_TMAX_TSKID];
    flgptn_t flg_m;
    flgptn_t ext_en_m;
    logic [31:0] rng;

    tb_clock_gen u_clk (
        .clk (clk)
    );

    rtos_top uut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_we_i     (wb_we_i),
        .wb_sel_i    (wb_sel_i),
        .wb_stb_i    (wb_stb_i),
        .extflg_i    (extflg_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .irq_o       (irq_o),
        .top_tskid_o (top_tskid_o),
        .run_tskid_o (run_tskid_o)
    );

    // ------------------------------
    // helpers
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // most urgent ready task, lowest id among equals
    function automatic tskid_t ref_top();
        tskid_t top;
        top = '0;
        for (int p = int'(`RTOS_INIT_TSKPRI); p >= 0; p--) begin
            for (int i = `RTOS_TMAX_TSKID; i >= 1; i--) begin
                if (ready_m[i] && (pri_m[i] == tskpri_t'(p))) begin
                    top = tskid_t'(i);
                end
            end
        end
        return top;
    endfunction

    // flag pattern after one edge, uses the enable before that edge
    function automatic flgptn_t next_flags(input flgptn_t cur, input logic set,
                                           input logic clr, input wb_dat_t d,
                                           input flgptn_t ext);
        flgptn_t nxt;
        nxt = cur;
        if (clr) begin
            nxt = nxt & flgptn_t'(d);
        end
        if (set) begin
            nxt = nxt | flgptn_t'(d);
        end
        return nxt | (ext_en_m & ext);
    endfunction

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_dat(input wb_dat_t got, input wb_dat_t exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, expected %h, got %h", $time, msg, exp, got);
            stop_run();
        end
    endtask

    task automatic check_tskid(input tskid_t got, input tskid_t exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, expected %0d, got %0d", $time, msg, exp, got);
            stop_run();
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, expected %b, got %b", $time, msg, exp, got);
            stop_run();
        end
    endtask

    // one strobe cycle, starts and ends on a falling edge
    task automatic bus_cycle(input logic we, input opcode_t op, input logic [7:0] id,
                             input wb_dat_t dat, input logic [3:0] sel,
                             output wb_dat_t rdat);
        int waited;
        wb_adr_i = {op, id};
        wb_dat_i = dat;
        wb_we_i  = we;
        wb_sel_i = sel;
        wb_stb_i = 1'b1;
        waited   = 0;
        #1;
        while (!wb_ack_o) begin
            if (waited >= ACK_LIMIT) begin
                $display("bus access at %0t was never acknowledged", $time);
                stop_run();
            end
            waited++;
            #1;
        end
        #10;
        rdat = wb_dat_o;
        @(posedge clk);
        @(negedge clk);
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic write_reg(input opcode_t op, input logic [7:0] id, input wb_dat_t dat);
        wb_dat_t unused;
        bus_cycle(1'b1, op, id, dat, 4'hf, unused);
    endtask

    task automatic read_reg(input opcode_t op, input logic [7:0] id, output wb_dat_t rdat);
        bus_cycle(1'b0, op, id, '0, 4'hf, rdat);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
        end
    endtask

    // run length guard
    initial begin
        for (int c = 0; c < CYCLE_LIMIT; c++) begin
            @(posedge clk);
        end
        $display("simulation ran past %0d cycles without finishing", CYCLE_LIMIT);
        stop_run();
    end

    // ------------------------------
    // stimulus and checks
    initial begin
        wb_dat_t     rdat;
        wb_dat_t     data;
        wb_dat_t     exp_stat;
        wb_dat_t     exp_pri;
        logic [7:0]  id;
        logic [3:0]  sel;
        opcode_t     op;
        logic        valid;
        tskid_t      t;
        flgptn_t     ext;
        systim_t     v;
        systim_t     snap_exp;
        int          k;

        arst_n_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_we_i  = 1'b0;
        wb_sel_i = '0;
        wb_stb_i = 1'b0;
        extflg_i = '0;
        rng      = 32'hfe88d3ee;
        flg_m    = '0;
        ext_en_m = '0;
        for (int i = 1; i <= `RTOS_TMAX_TSKID; i++) begin
            ready_m[i] = 1'b0;
            pri_m[i]   = `RTOS_INIT_TSKPRI;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // configuration and reset state
        read_reg(`RTOS_OP_SYS_CFG, `RTOS_CFG_CORE_ID, rdat);
        check_dat(rdat, `RTOS_CORE_ID, "core id read");
        read_reg(`RTOS_OP_SYS_CFG, `RTOS_CFG_TMAX_TSKID, rdat);
        check_dat(rdat, wb_dat_t'(`RTOS_TMAX_TSKID), "task count read");
        read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_TOP_TSKID, rdat);
        check_dat(rdat, '0, "top task after reset");
        read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_RUN_TSKID, rdat);
        check_dat(rdat, '0, "running task after reset");
        read_reg(8'h55, 8'h00, rdat);
        check_dat(rdat, '0, "unknown address read");
        check_tskid(top_tskid_o, '0, "top task output after reset");
        check_tskid(run_tskid_o, '0, "running task output after reset");
        check_irq(irq_o, 1'b0, "irq after reset");

        // ------------------------------
        // random task commands
        for (int n = 0; n < TSK_OPS; n++) begin
            rng = xorshift(rng);
            if (rng[1:0] == 2'd1) begin
                op = `RTOS_OP_SLP_TSK;
            end else if (rng[1:0] == 2'd2) begin
                op = `RTOS_OP_CHG_PRI;
            end else begin
                op = `RTOS_OP_WUP_TSK;
            end
            id = {4'h0, rng[7:4]};
            if (rng[10:8] == 3'd0) begin
                id[7:4] = rng[14:11];
            end
            sel = 4'hf;
            if (rng[17:15] == 3'd0) begin
                sel = rng[21:18];
                if (&sel) begin
                    sel = 4'h3;
                end
            end
            rng  = xorshift(rng);
            data = rng;
            bus_cycle(1'b1, op, id, data, sel, rdat);
            if ((&sel) && (id[7:4] == 4'h0) && (id[3:0] != 4'h0)) begin
                t = id[3:0];
                if (op == `RTOS_OP_WUP_TSK) begin
                    ready_m[t] = 1'b1;
                end else if (op == `RTOS_OP_SLP_TSK) begin
                    ready_m[t] = 1'b0;
                end else begin
                    pri_m[t] = data[3:0];
                end
            end
            check_tskid(top_tskid_o, ref_top(), "top task output");
            read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_TOP_TSKID, rdat);
            check_dat(rdat, wb_dat_t'(ref_top()), "TOP_TSKID read");

            rng = xorshift(rng);
            id  = {4'h0, rng[3:0]};
            if (rng[6:4] == 3'd0) begin
                id[7:4] = rng[10:7];
            end
            valid    = (id[7:4] == 4'h0) && (id[3:0] != 4'h0);
            exp_stat = '0;
            exp_pri  = '0;
            if (valid) begin
                exp_stat = wb_dat_t'(ready_m[id[3:0]]);
                exp_pri  = wb_dat_t'(pri_m[id[3:0]]);
            end
            read_reg(`RTOS_OP_REF_TSKSTAT, id, rdat);
            check_dat(rdat, exp_stat, "REF_TSKSTAT read");
            read_reg(`RTOS_OP_GET_PRI, id, rdat);
            check_dat(rdat, exp_pri, "GET_PRI read");
        end

        // ------------------------------
        // interrupt on task switch
        for (int i = 1; i <= `RTOS_TMAX_TSKID; i++) begin
            write_reg(`RTOS_OP_SLP_TSK, 8'(i), '0);
            ready_m[i] = 1'b0;
        end
        write_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_RUN_TSKID, '0);
        write_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_IRQ_EN, 32'd1);
        read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_IRQ_EN, rdat);
        check_dat(rdat, 32'd1, "IRQ_EN read after enable");
        idle_cycles(2);
        check_irq(irq_o, 1'b0, "irq with no task ready");
        write_reg(`RTOS_OP_CHG_PRI, 8'd7, 32'd3);
        pri_m[7] = 4'd3;
        write_reg(`RTOS_OP_WUP_TSK, 8'd7, '0);
        ready_m[7] = 1'b1;
        check_tskid(top_tskid_o, ref_top(), "top task after wake-up");
        check_irq(irq_o, 1'b0, "irq just after wake-up edge");
        idle_cycles(1);
        check_irq(irq_o, 1'b0, "irq one edge after wake-up");
        idle_cycles(1);
        check_irq(irq_o, 1'b1, "irq two edges after wake-up");
        read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_IRQ_STS, rdat);
        check_dat(rdat, 32'd1, "IRQ_STS read while pending");
        read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_COPY_TSKID, rdat);
        check_dat(rdat, wb_dat_t'(ref_top()), "copy read");
        check_tskid(run_tskid_o, ref_top(), "running task after copy");
        idle_cycles(1);
        check_irq(irq_o, 1'b0, "irq one edge after copy");
        read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_RUN_TSKID, rdat);
        check_dat(rdat, wb_dat_t'(ref_top()), "RUN_TSKID read after copy");

        // disabled interrupt stays low
        write_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_IRQ_EN, '0);
        read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_IRQ_EN, rdat);
        check_dat(rdat, '0, "IRQ_EN read after disable");
        write_reg(`RTOS_OP_CHG_PRI, 8'd2, 32'd1);
        pri_m[2] = 4'd1;
        write_reg(`RTOS_OP_WUP_TSK, 8'd2, '0);
        ready_m[2] = 1'b1;
        check_tskid(top_tskid_o, ref_top(), "top task after second wake-up");
        for (int i = 0; i < 4; i++) begin
            idle_cycles(1);
            check_irq(irq_o, 1'b0, "irq while disabled");
        end
        read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_IRQ_STS, rdat);
        check_dat(rdat, '0, "IRQ_STS read while disabled");
        write_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_IRQ_FORCE, 32'd1);
        check_irq(irq_o, 1'b1, "irq with force set");
        read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_IRQ_STS, rdat);
        check_dat(rdat, 32'd1, "IRQ_STS read with force set");
        write_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_IRQ_FORCE, '0);
        check_irq(irq_o, 1'b0, "irq with force cleared");
        // mismatch still held, so enabling raises the irq at once
        write_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_IRQ_EN, 32'd1);
        check_irq(irq_o, 1'b1, "irq after enable with pending switch");
        read_reg(`RTOS_OP_CPU_CTL, `RTOS_CTL_COPY_TSKID, rdat);
        check_dat(rdat, wb_dat_t'(ref_top()), "second copy read");
        check_tskid(run_tskid_o, ref_top(), "running task after second copy");
        idle_cycles(1);
        check_irq(irq_o, 1'b0, "irq one edge after second copy");

        // ------------------------------
        // event flags
        for (int n = 0; n < FLG_OPS; n++) begin
            rng  = xorshift(rng);
            op   = rng[1:0] == 2'd1 ? `RTOS_OP_CLR_FLG :
                   rng[1:0] == 2'd2 ? `RTOS_OP_ENA_FLG_EXT : `RTOS_OP_SET_FLG;
            rng  = xorshift(rng);
            data = rng;
            rng  = xorshift(rng);
            ext  = rng;
            extflg_i = ext;
            write_reg(op, 8'h00, data);
            flg_m = next_flags(flg_m, op == `RTOS_OP_SET_FLG, op == `RTOS_OP_CLR_FLG,
                               data, ext);
            if (op == `RTOS_OP_ENA_FLG_EXT) begin
                ext_en_m = flgptn_t'(data);
            end
            read_reg(`RTOS_OP_REF_FLGPTN, 8'h00, rdat);
            check_dat(rdat, wb_dat_t'(flg_m), "REF_FLGPTN read");
            flg_m = next_flags(flg_m, 1'b0, 1'b0, '0, ext);
        end

        // ------------------------------
        // system time load and capture
        for (int n = 0; n < TIM_RUNS; n++) begin
            rng = xorshift(rng);
            v[31:0] = rng;
            rng = xorshift(rng);
            v[63:32] = rng;
            if (n == 0) begin
                v = 64'h0000_0001_ffff_fff8;
            end
            k = 1 + int'(rng[4:0] % 5'd20);
            write_reg(`RTOS_OP_SYSTIM_LO, 8'h00, v[31:0]);
            write_reg(`RTOS_OP_SYSTIM_HI, 8'h00, v[63:32]);
            write_reg(`RTOS_OP_SET_TIM, 8'h00, '0);
            idle_cycles(k - 1);
            write_reg(`RTOS_OP_GET_TIM, 8'h00, '0);
            snap_exp = v + systim_t'(k - 1);
            read_reg(`RTOS_OP_SYSTIM_LO, 8'h00, rdat);
            check_dat(rdat, snap_exp[31:0], "SYSTIM_LO read");
            read_reg(`RTOS_OP_SYSTIM_HI, 8'h00, rdat);
            check_dat(rdat, snap_exp[63:32], "SYSTIM_HI read");
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
// testbench clock source, free-running clock with a period of 100
module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

// File: source/rtos_top.sv
// rtos kernel front end top: bus decoder, ready queue, cpu control, flags, time
`include "rtos_consts.svh"

module rtos_top (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic [`RTOS_WB_ADR_WIDTH-1:0] wb_adr_i,
    input  rtos_pkg::wb_dat_t             wb_dat_i,
    input  logic                          wb_we_i,
    input  logic [`RTOS_WB_SEL_WIDTH-1:0] wb_sel_i,
    input  logic                          wb_stb_i,
    input  rtos_pkg::flgptn_t             extflg_i,
    output rtos_pkg::wb_dat_t             wb_dat_o,
    output logic                          wb_ack_o,
    output logic                          irq_o,
    output rtos_pkg::tskid_t              top_tskid_o,
    output rtos_pkg::tskid_t              run_tskid_o
);
    import rtos_pkg::*;

    logic    wup_tsk, slp_tsk, chg_pri;
    tskid_t  tskid;
    tskpri_t tskpri;
    logic    tskstat;
    tskpri_t rd_tskpri;
    logic    set_flg, clr_flg, ena_ext;
    logic    get_tim, set_tim, wr_lo, wr_hi;
    logic    wr_run, copy, wr_irq_en, wr_irq_force;
    logic    irq_en;
    wb_dat_t dat;
    flgptn_t flgptn;
    systim_t snap;

    // no wait states
    assign wb_ack_o = wb_stb_i;

    rtos_bus_decode u_decode (
        .wb_adr_i, .wb_dat_i, .wb_we_i, .wb_sel_i, .wb_stb_i,
        .top_tskid_i (top_tskid_o), .run_tskid_i (run_tskid_o),
        .tskstat_i (tskstat), .tskpri_i (rd_tskpri),
        .irq_en_i (irq_en), .irq_i (irq_o),
        .flgptn_i (flgptn), .snap_i (snap),
        .wup_tsk_o (wup_tsk), .slp_tsk_o (slp_tsk), .chg_pri_o (chg_pri),
        .tskid_o (tskid), .tskpri_o (tskpri),
        .set_flg_o (set_flg), .clr_flg_o (clr_flg), .ena_ext_o (ena_ext),
        .get_tim_o (get_tim), .set_tim_o (set_tim), .wr_lo_o (wr_lo), .wr_hi_o (wr_hi),
        .wr_run_o (wr_run), .copy_o (copy),
        .wr_irq_en_o (wr_irq_en), .wr_irq_force_o (wr_irq_force),
        .dat_o (dat), .wb_dat_o
    );

    rtos_ready_queue u_ready_queue (
        .clk, .arst_n_i,
        .wup_tsk_i (wup_tsk), .slp_tsk_i (slp_tsk), .chg_pri_i (chg_pri),
        .tskid_i (tskid), .tskpri_i (tskpri),
        .top_tskid_o, .tskstat_o (tskstat), .tskpri_o (rd_tskpri)
    );

    rtos_cpu_ctl u_cpu_ctl (
        .clk, .arst_n_i,
        .top_tskid_i (top_tskid_o), .wr_run_i (wr_run), .copy_i (copy),
        .wr_irq_en_i (wr_irq_en), .wr_irq_force_i (wr_irq_force), .dat_i (dat),
        .run_tskid_o, .irq_en_o (irq_en), .irq_o
    );

    rtos_event_flag u_event_flag (
        .clk, .arst_n_i,
        .set_flg_i (set_flg), .clr_flg_i (clr_flg), .ena_ext_i (ena_ext),
        .dat_i (dat), .extflg_i, .flgptn_o (flgptn)
    );

    rtos_systim u_systim (
        .clk, .arst_n_i,
        .get_tim_i (get_tim), .set_tim_i (set_tim), .wr_lo_i (wr_lo), .wr_hi_i (wr_hi),
        .dat_i (dat), .snap_o (snap)
    );

endmodule

// File: source/rtos_systim.sv
// rtos system time: free-running 64-bit counter with snapshot register
`include "rtos_consts.svh"

module rtos_systim (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              get_tim_i,
    input  logic              set_tim_i,
    input  logic              wr_lo_i,
    input  logic              wr_hi_i,
    input  rtos_pkg::wb_dat_t dat_i,
    output rtos_pkg::systim_t snap_o
);
    import rtos_pkg::*;

    systim_t time_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            time_q <= '0;
        end else if (set_tim_i) begin
            time_q <= snap_o;
        end else begin
            time_q <= time_q + systim_t'(1);
        end
    end

    // snapshot, staged load value or captured time
    always_ff @(posedge clk) begin
        if (get_tim_i) begin
            snap_o <= time_q;
        end
        if (wr_lo_i) begin
            snap_o[`RTOS_WB_DAT_WIDTH-1:0] <= dat_i;
        end
        if (wr_hi_i) begin
            snap_o[`RTOS_SYSTIM_WIDTH-1:`RTOS_WB_DAT_WIDTH] <= dat_i;
        end
    end

endmodule

// File: source/rtos_event_flag.sv
// rtos event flag: pattern register with set, clear and external merge
module rtos_event_flag (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              set_flg_i,
    input  logic              clr_flg_i,
    input  logic              ena_ext_i,
    input  rtos_pkg::wb_dat_t dat_i,
    input  rtos_pkg::flgptn_t extflg_i,
    output rtos_pkg::flgptn_t flgptn_o
);
    import rtos_pkg::*;

    flgptn_t ext_en_q;
    flgptn_t clr_mask;
    flgptn_t set_ptn;

    // clear is an and-mask, all ones when idle
    assign clr_mask = clr_flg_i ? flgptn_t'(dat_i) : '1;
    assign set_ptn  = (set_flg_i ? flgptn_t'(dat_i) : '0) | (ext_en_q & extflg_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flgptn_o <= '0;
            ext_en_q <= '0;
        end else begin
            flgptn_o <= (flgptn_o & clr_mask) | set_ptn;
            if (ena_ext_i) begin
                ext_en_q <= flgptn_t'(dat_i);
            end
        end
    end

endmodule

// File: source/rtos_cpu_ctl.sv
// rtos cpu control: running task, switch detection and interrupt
module rtos_cpu_ctl (
    input  logic              clk,
    input  logic              arst_n_i,
    input  rtos_pkg::tskid_t  top_tskid_i,
    input  logic              wr_run_i,
    input  logic              copy_i,
    input  logic              wr_irq_en_i,
    input  logic              wr_irq_force_i,
    input  rtos_pkg::wb_dat_t dat_i,
    output rtos_pkg::tskid_t  run_tskid_o,
    output logic              irq_en_o,
    output logic              irq_o
);
    import rtos_pkg::*;

    tskid_t run_q;
    logic   irq_force_q;
    logic   switch_q;
    logic   irq_q;
    logic   mismatch;

    assign mismatch = (top_tskid_i != run_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q       <= '0;
            irq_en_o    <= 1'b0;
            irq_force_q <= 1'b0;
            switch_q    <= 1'b0;
            irq_q       <= 1'b0;
        end else begin
            if (wr_run_i) begin
                run_q <= tskid_t'(dat_i);
            end else if (copy_i) begin
                run_q <= top_tskid_i;
            end
            if (wr_irq_en_i) begin
                irq_en_o <= dat_i[0];
            end
            if (wr_irq_force_i) begin
                irq_force_q <= dat_i[0];
            end
            // mismatch must hold two edges in a row
            switch_q <= mismatch;
            irq_q    <= mismatch && switch_q;
        end
    end

    assign run_tskid_o = run_q;
    assign irq_o       = (irq_q && irq_en_o) || irq_force_q;

endmodule

// File: source/rtos_ready_queue.sv
// rtos ready queue: per-task ready bit and priority, picks the top task
`include "rtos_consts.svh"

module rtos_ready_queue (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              wup_tsk_i,
    input  logic              slp_tsk_i,
    input  logic              chg_pri_i,
    input  rtos_pkg::tskid_t  tskid_i,
    input  rtos_pkg::tskpri_t tskpri_i,
    output rtos_pkg::tskid_t  top_tskid_o,
    output logic              tskstat_o,
    output rtos_pkg::tskpri_t tskpri_o
);
    import rtos_pkg::*;

    logic    [`RTOS_TMAX_TSKID:1] ready_q;
    tskpri_t [`RTOS_TMAX_TSKID:1] pri_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q <= '0;
            pri_q   <= {`RTOS_TMAX_TSKID{`RTOS_INIT_TSKPRI}};
        end else begin
            for (int i = 1; i <= `RTOS_TMAX_TSKID; i++) begin
                if (tskid_i == tskid_t'(i)) begin
                    if (wup_tsk_i) begin
                        ready_q[i] <= 1'b1;
                    end
                    if (slp_tsk_i) begin
                        ready_q[i] <= 1'b0;
                    end
                    if (chg_pri_i) begin
                        pri_q[i] <= tskpri_i;
                    end
                end
            end
        end
    end

    // ------------------------------
    // top task, ties go to lower id
    always_comb begin : top_select
        tskid_t  best_id;
        tskpri_t best_pri;
        best_id  = '0;
        best_pri = '1;
        for (int i = 1; i <= `RTOS_TMAX_TSKID; i++) begin
            if (ready_q[i] && (best_id == '0 || pri_q[i] < best_pri)) begin
                best_id  = tskid_t'(i);
                best_pri = pri_q[i];
            end
        end
        top_tskid_o = best_id;
    end

    // state of the addressed task, id 0 reads as 0
    always_comb begin
        tskstat_o = 1'b0;
        tskpri_o  = '0;
        for (int i = 1; i <= `RTOS_TMAX_TSKID; i++) begin
            if (tskid_i == tskid_t'(i)) begin
                tskstat_o = ready_q[i];
                tskpri_o  = pri_q[i];
            end
        end
    end

endmodule

// File: source/rtos_bus_decode.sv
// rtos bus decoder: command strobes from bus writes and the read data mux
`include "rtos_consts.svh"

module rtos_bus_decode (
    input  logic [`RTOS_WB_ADR_WIDTH-1:0] wb_adr_i,
    input  rtos_pkg::wb_dat_t             wb_dat_i,
    input  logic                          wb_we_i,
    input  logic [`RTOS_WB_SEL_WIDTH-1:0] wb_sel_i,
    input  logic                          wb_stb_i,
    input  rtos_pkg::tskid_t              top_tskid_i,
    input  rtos_pkg::tskid_t              run_tskid_i,
    input  logic                          tskstat_i,
    input  rtos_pkg::tskpri_t             tskpri_i,
    input  logic                          irq_en_i,
    input  logic                          irq_i,
    input  rtos_pkg::flgptn_t             flgptn_i,
    input  rtos_pkg::systim_t             snap_i,
    output logic                          wup_tsk_o,
    output logic                          slp_tsk_o,
    output logic                          chg_pri_o,
    output rtos_pkg::tskid_t              tskid_o,
    output rtos_pkg::tskpri_t             tskpri_o,
    output logic                          set_flg_o,
    output logic                          clr_flg_o,
    output logic                          ena_ext_o,
    output logic                          get_tim_o,
    output logic                          set_tim_o,
    output logic                          wr_lo_o,
    output logic                          wr_hi_o,
    output logic                          wr_run_o,
    output logic                          copy_o,
    output logic                          wr_irq_en_o,
    output logic                          wr_irq_force_o,
    output rtos_pkg::wb_dat_t             dat_o,
    output rtos_pkg::wb_dat_t             wb_dat_o
);
    import rtos_pkg::*;

    opcode_t  opcode;
    rtos_id_u id;
    logic     wr;
    logic     rd;
    logic     tsk_valid;

    assign {opcode, id} = wb_adr_i;

    // writes need every byte lane
    assign wr = wb_stb_i && wb_we_i && (&wb_sel_i);
    assign rd = wb_stb_i && !wb_we_i;

    // task 1..15 only
    assign tsk_valid = (id.tsk.zero == '0) && (id.tsk.tskid != '0);
    assign tskid_o   = tsk_valid ? id.tsk.tskid : '0;
    assign tskpri_o  = tskpri_t'(wb_dat_i);
    assign dat_o     = wb_dat_i;

    // read of copy register moves top task into running task
    assign copy_o = rd && (opcode == `RTOS_OP_CPU_CTL) && (id.reg_sel == `RTOS_CTL_COPY_TSKID);

    // ------------------------------
    // write strobes
    always_comb begin
        wup_tsk_o      = 1'b0;
        slp_tsk_o      = 1'b0;
        chg_pri_o      = 1'b0;
        set_flg_o      = 1'b0;
        clr_flg_o      = 1'b0;
        ena_ext_o      = 1'b0;
        get_tim_o      = 1'b0;
        set_tim_o      = 1'b0;
        wr_lo_o        = 1'b0;
        wr_hi_o        = 1'b0;
        wr_run_o       = 1'b0;
        wr_irq_en_o    = 1'b0;
        wr_irq_force_o = 1'b0;
        if (wr) begin
            case (opcode)
                `RTOS_OP_CPU_CTL: begin
                    case (id.reg_sel)
                        `RTOS_CTL_RUN_TSKID,
                        `RTOS_CTL_COPY_TSKID: wr_run_o       = 1'b1;
                        `RTOS_CTL_IRQ_EN:     wr_irq_en_o    = 1'b1;
                        `RTOS_CTL_IRQ_FORCE:  wr_irq_force_o = 1'b1;
                        default: ;
                    endcase
                end
                `RTOS_OP_WUP_TSK:     wup_tsk_o = tsk_valid;
                `RTOS_OP_SLP_TSK:     slp_tsk_o = tsk_valid;
                `RTOS_OP_CHG_PRI:     chg_pri_o = tsk_valid;
                `RTOS_OP_SET_FLG:     set_flg_o = 1'b1;
                `RTOS_OP_CLR_FLG:     clr_flg_o = 1'b1;
                `RTOS_OP_ENA_FLG_EXT: ena_ext_o = 1'b1;
                `RTOS_OP_SET_TIM:     set_tim_o = 1'b1;
                `RTOS_OP_GET_TIM:     get_tim_o = 1'b1;
                `RTOS_OP_SYSTIM_LO:   wr_lo_o   = 1'b1;
                `RTOS_OP_SYSTIM_HI:   wr_hi_o   = 1'b1;
                default: ;
            endcase
        end
    end

    // ------------------------------
    // read mux, unknown addresses give 0
    always_comb begin
        wb_dat_o = '0;
        case (opcode)
            `RTOS_OP_SYS_CFG: begin
                case (id.reg_sel)
                    `RTOS_CFG_CORE_ID:    wb_dat_o = `RTOS_CORE_ID;
                    `RTOS_CFG_TMAX_TSKID: wb_dat_o = wb_dat_t'(`RTOS_TMAX_TSKID);
                    default: ;
                endcase
            end
            `RTOS_OP_CPU_CTL: begin
                case (id.reg_sel)
                    `RTOS_CTL_TOP_TSKID:  wb_dat_o = wb_dat_t'(top_tskid_i);
                    `RTOS_CTL_RUN_TSKID:  wb_dat_o = wb_dat_t'(run_tskid_i);
                    `RTOS_CTL_COPY_TSKID: wb_dat_o = wb_dat_t'(top_tskid_i);
                    `RTOS_CTL_IRQ_EN:     wb_dat_o = wb_dat_t'(irq_en_i);
                    `RTOS_CTL_IRQ_STS:    wb_dat_o = wb_dat_t'(irq_i);
                    default: ;
                endcase
            end
            `RTOS_OP_REF_TSKSTAT: wb_dat_o = tsk_valid ? wb_dat_t'(tskstat_i) : '0;
            `RTOS_OP_GET_PRI:     wb_dat_o = tsk_valid ? wb_dat_t'(tskpri_i) : '0;
            `RTOS_OP_REF_FLGPTN:  wb_dat_o = wb_dat_t'(flgptn_i);
            `RTOS_OP_SYSTIM_LO:   wb_dat_o = snap_i[`RTOS_WB_DAT_WIDTH-1:0];
            `RTOS_OP_SYSTIM_HI:   wb_dat_o = snap_i[`RTOS_SYSTIM_WIDTH-1:`RTOS_WB_DAT_WIDTH];
            default: ;
        endcase
    end

endmodule

// File: source/rtos_pkg.sv
// rtos kernel shared types for task, flag, time and bus fields
`include "rtos_consts.svh"

package rtos_pkg;

    typedef logic [`RTOS_WB_DAT_WIDTH-1:0] wb_dat_t;
    typedef logic [7:0] opcode_t;

    // 0 means no task
    typedef logic [`RTOS_TSKID_WIDTH-1:0] tskid_t;
    // smaller value is more urgent
    typedef logic [`RTOS_TSKPRI_WIDTH-1:0] tskpri_t;

    typedef logic [`RTOS_FLGPTN_WIDTH-1:0] flgptn_t;
    typedef logic [`RTOS_SYSTIM_WIDTH-1:0] systim_t;

    // id field as task reference, upper part must be zero
    typedef struct packed {
        logic [3:0] zero;
        tskid_t     tskid;
    } tsk_sel_s;

    // id field, register code or task reference
    typedef union packed {
        logic [7:0] reg_sel;
        tsk_sel_s   tsk;
    } rtos_id_u;

endpackage

// File: rtos_consts.svh
// rtos kernel constants: bus widths, task sizes, opcodes and register ids
`ifndef RTOS_CONSTS_SVH
`define RTOS_CONSTS_SVH

// ------------------------------
// sizes
`define RTOS_WB_ADR_WIDTH       16
`define RTOS_WB_DAT_WIDTH       32
`define RTOS_WB_SEL_WIDTH       4
`define RTOS_TMAX_TSKID         15
`define RTOS_TSKID_WIDTH        4
`define RTOS_TSKPRI_WIDTH       4
`define RTOS_FLGPTN_WIDTH       32
`define RTOS_SYSTIM_WIDTH       64
// lowest priority
`define RTOS_INIT_TSKPRI        4'd15
`define RTOS_CORE_ID            32'h834f5452

// ------------------------------
// opcodes, upper address byte
`define RTOS_OP_SYS_CFG         8'h00
`define RTOS_OP_CPU_CTL         8'h01
`define RTOS_OP_WUP_TSK         8'h10
`define RTOS_OP_SLP_TSK         8'h11
`define RTOS_OP_CHG_PRI         8'h1c
`define RTOS_OP_REF_TSKSTAT     8'h90
`define RTOS_OP_GET_PRI         8'h9c
`define RTOS_OP_SET_FLG         8'h31
`define RTOS_OP_CLR_FLG         8'h32
`define RTOS_OP_ENA_FLG_EXT     8'h3a
`define RTOS_OP_REF_FLGPTN      8'hb0
`define RTOS_OP_SET_TIM         8'h70
`define RTOS_OP_GET_TIM         8'hf0
`define RTOS_OP_SYSTIM_LO       8'hf2
`define RTOS_OP_SYSTIM_HI       8'hf3

// ------------------------------
// register ids, lower address byte
`define RTOS_CFG_CORE_ID        8'h00
`define RTOS_CFG_TMAX_TSKID     8'h20
`define RTOS_CTL_TOP_TSKID      8'h00
`define RTOS_CTL_RUN_TSKID      8'h04
`define RTOS_CTL_COPY_TSKID     8'h08
`define RTOS_CTL_IRQ_EN         8'h10
`define RTOS_CTL_IRQ_STS        8'h11
`define RTOS_CTL_IRQ_FORCE      8'h1f

`endif
